// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := vidTb
FILELIST  := compile.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJDIR)

// File: compile.f
verilog/vidPkg.sv
verilog/vidTiming.sv
verilog/scrollLayer.sv
verilog/objLayer.sv
verilog/layerMixer.sv
verilog/vidTop.sv
sim/vidTb.sv

// File: sim/vidTb.sv
// testbench for vidTop with random register writes and a timing and pixel reference model
// sync, blanking, scroll, object and reset checks with a closing report
`timescale 1ns/1ps

module vidTb;

    localparam int hsStart    = 487;
    localparam int hsLen      = 38;
    localparam int vsStart    = 251;
    localparam int vsLen      = 4;
    localparam int objSize    = 16;
    localparam int frameTicks = vidPkg::lineTicks * vidPkg::frameLines;

    logic clk, arstN, cen8, cfgWe;
    vidPkg::cfgRegE cfgAddr;
    logic [8:0] cfgData;
    logic [7:0] pixel;
    logic [8:0] pixX, pixY;
    logic hs, vs, hb, vb, lineStart, frameStart;

    vidTop #(.hsStart(hsStart), .hsLen(hsLen), .vsStart(vsStart), .vsLen(vsLen),
             .objSize(objSize)) dut (
        .clk, .arstN, .cen8, .cfgWe, .cfgAddr, .cfgData,
        .pixel, .pixX, .pixY, .hs, .vs, .hb, .vb, .lineStart, .frameStart
    );

    // model state for the counter, layer and mixer stages
    logic [8:0] mh, mv, mvr, mvr1;
    logic mhs, mvs, mhb, mvb, mls, mfs;
    logic [1:0] mvbp;
    vidPkg::vidTimingT d1, d2;
    vidPkg::layerPixT bgL, objL;
    logic [7:0] mPix;
    logic [8:0] sX, sY, oX, oY;
    logic [3:0] oC;
    logic pri;  // 0 = sprite in front

    integer seed = 32'h9ded;
    int errs = 0, testErrs, testsRun = 0, testsFailed = 0;
    string curTest;
    logic prevHs, prevVs;
    int hsCnt, vsLines;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic modelReset();
        mh = 0;
        mv = 240;
        mvr = 241;
        mvr1 = 242;
        mhs = 0;
        mvs = 0;
        mhb = 1;
        mvb = 1;
        mvbp = 2'b11;
        mls = 1;
        mfs = 0;
        d1 = '{hb: 1'b1, vb: 1'b1, default: '0};
        d2 = d1;
        bgL = '0;
        objL = '0;
        mPix = vidPkg::backdrop;
        sX = 0;
        sY = 0;
        oX = 0;
        oY = 0;
        oC = 0;
        pri = 0;
        prevHs = 0;
        prevVs = 0;
        hsCnt = 0;
        vsLines = 0;
    endtask

    // one cen8 tick of the whole pipeline followed by the register write
    task automatic modelStep(input logic we, input vidPkg::cfgRegE a, input logic [8:0] d);
        vidPkg::vidTimingT t;
        logic [8:0] cx, cy, tm;
        logic [3:0] ti;
        logic blankNow, hit;
        t = '{hdump: mh, vdump: mv, lineStart: mls, frameStart: mfs,
              hs: mhs, vs: mvs, hb: mhb, vb: mvb};
        if (d1.hb || d1.vb) mPix = vidPkg::backdrop;
        else if (!pri && objL.opaque) mPix = {vidPkg::objBank, objL.idx};
        else if (bgL.opaque) mPix = {vidPkg::bgBank, bgL.idx};
        else if (pri && objL.opaque) mPix = {vidPkg::objBank, objL.idx};
        else mPix = vidPkg::backdrop;
        d2 = d1;
        d1 = t;
        cx = mh + sX;
        cy = mv + sY;
        tm = (cx ^ cy) >> 3;  // 8 pixel tiles
        ti = tm[3:0];
        bgL = '{opaque: ti != 0, idx: ti};
        hit = mh >= oX && int'(mh) < int'(oX) + objSize
              && mv >= oY && int'(mv) < int'(oY) + objSize;
        objL = hit ? '{opaque: oC != 0, idx: oC} : '0;
        blankNow = mv < vidPkg::vVisStart || mv >= vidPkg::vVisEnd;
        mhb = mh >= vidPkg::hVisEnd || mh < vidPkg::hVisStart;
        mls = mh == 511 && mv > 12 && mv < 240;
        if (mh == 9'(hsStart)) begin
            mhs = 1;
            if (mv == 9'(vsStart)) mvs = 1;
            if (mv == 9'(vsStart + vsLen)) mvs = 0;
        end
        if (mh == 9'((hsStart + hsLen) % 512)) mhs = 0;
        mvbp[0] = blankNow;
        if (mh == 511) begin
            mfs = mvr1 == 261;
            mv = mvr;
            mvr = mvr1;
            mvr1 = (mvr1 == 261) ? 9'd0 : mvr1 + 9'd1;
            mvb = mvbp[1];
            mvbp[1] = blankNow;
            mh = 0;
        end else begin
            mfs = 0;
            mh = mh + 9'd1;
        end
        if (we) begin
            case (a)
                vidPkg::regScrollX: sX = d;
                vidPkg::regScrollY: sY = d;
                vidPkg::regObjX: oX = d;
                vidPkg::regObjY: oY = d;
                vidPkg::regObjColor: oC = d[3:0];
                vidPkg::regPriority: pri = d[0];
                default: ;
            endcase
        end
    endtask

    task automatic checkVal(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("ERR %s %s expected %0h actual %0h", curTest, what, exp, act);
            errs++;
        end
    endtask

    task automatic checkOutputs();
        checkVal("pixX", d2.hdump, pixX);
        checkVal("pixY", d2.vdump, pixY);
        checkVal("hs", d2.hs, hs);
        checkVal("vs", d2.vs, vs);
        checkVal("hb", d2.hb, hb);
        checkVal("vb", d2.vb, vb);
        checkVal("lineStart", d2.lineStart, lineStart);
        checkVal("frameStart", d2.frameStart, frameStart);
        checkVal("pixel", mPix, pixel);
        if (hb || vb) checkVal("blank pixel", vidPkg::backdrop, pixel);
        if (hs && !prevHs) begin
            // hs is registered from hdump, so it first shows one pixel after hsStart
            checkVal("hs start pixX", (hsStart + 1) % vidPkg::lineTicks, pixX);
            hsCnt = 0;
            if (vs) vsLines++;
        end
        if (hs) hsCnt++;
        if (!hs && prevHs) checkVal("hs length", hsLen, hsCnt);
        assert (vs == prevVs || (hs && !prevHs)) else begin
            $display("%s: vs changed away from an hs leading edge", curTest);
            errs++;
        end
        if (!vs && prevVs) checkVal("vs lines", vsLen, vsLines);
        if (vs && !prevVs) vsLines = 1;
        prevHs = hs;
        prevVs = vs;
    endtask

    task automatic tick(input logic we, input vidPkg::cfgRegE a, input logic [8:0] d);
        @(posedge clk);
        cen8 <= 1'b1;
        cfgWe <= we;
        cfgAddr <= a;
        cfgData <= d;
        @(posedge clk);
        cen8 <= 1'b0;
        cfgWe <= 1'b0;
        modelStep(we, a, d);
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic idle(input int n);
        repeat (n) tick(1'b0, vidPkg::regScrollX, 9'd0);
    endtask

    // counts ticks up to the next frame pulse and gives -1 on timeout
    task automatic waitFrame(output int n);
        n = 0;
        do begin
            idle(1);
            n++;
        end while (!frameStart && n <= frameTicks + 8);
        if (!frameStart) begin
            $display("%s: timeout waiting for frameStart", curTest);
            errs++;
            n = -1;
        end
    endtask

    task automatic writeReg(input vidPkg::cfgRegE a, input logic [8:0] d);
        int n;
        n = 0;
        while (!(vb && hb) && n < frameTicks) begin
            idle(1);
            n++;
        end
        if (!(vb && hb)) begin
            $display("%s: timeout waiting for vertical blank", curTest);
            errs++;
        end
        tick(1'b1, a, d);
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrs = errs;
        testsRun++;
    endtask

    task automatic endTest();
        if (errs != testErrs) testsFailed++;
        $display("%s finished with %0d errors", curTest, errs - testErrs);
    endtask

    initial begin
        int n, r, i;
        arstN = 1'b0;
        cen8 = 1'b0;
        cfgWe = 1'b0;
        cfgAddr = vidPkg::regScrollX;
        cfgData = 9'd0;
        modelReset();
        repeat (16) @(posedge clk);
        arstN <= 1'b1;

        startTest("geometry");  // also covers sync and blanking
        waitFrame(n);
        waitFrame(n);
        checkVal("frame ticks", frameTicks, n);
        endTest();

        startTest("scroll");
        writeReg(vidPkg::regObjX, 9'd500);  // parked in horizontal blank
        for (i = 0; i < 3; i++) begin
            r = $random(seed);
            writeReg(vidPkg::regScrollX, r[8:0]);
            writeReg(vidPkg::regScrollY, r[24:16]);
            waitFrame(n);
            waitFrame(n);
        end
        endTest();

        startTest("object");
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            writeReg(vidPkg::regObjX, 9'((r & 511) % 448));
            writeReg(vidPkg::regObjY, 9'(((r >> 9) & 255) % 240));
            writeReg(vidPkg::regObjColor, (i == 0) ? 9'd0 : {5'd0, r[20:17]});
            writeReg(vidPkg::regPriority, {8'd0, i[0]});
            waitFrame(n);
            waitFrame(n);
        end
        endTest();

        startTest("reset");
        r = $random(seed);
        idle(1000 + (r & 4095));
        @(posedge clk);
        arstN <= 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        modelReset();
        checkVal("pixel", vidPkg::backdrop, pixel);
        checkVal("hb", 1, hb);
        checkVal("vb", 1, vb);
        checkVal("hs", 0, hs);
        checkVal("vs", 0, vs);
        checkVal("pixX", 0, pixX);
        checkVal("pixY", 0, pixY);
        checkVal("lineStart", 0, lineStart);
        checkVal("frameStart", 0, frameStart);
        @(posedge clk);
        arstN <= 1'b1;
        waitFrame(n);
        waitFrame(n);
        endTest();

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errs);
        if (errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/layerMixer.sv
// priority mixer: layer select, blank forcing, timing aligned to the pixel
`timescale 1ns/1ps

module layerMixer (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    cen8,
    input  vidPkg::vidTimingT       tim,
    input  vidPkg::layerPixT        bgPix,
    input  vidPkg::layerPixT        objPix,
    input  logic                    cfgWe,
    input  vidPkg::cfgRegE          cfgAddr,
    input  logic [8:0]              cfgData,
    output logic [vidPkg::pixW-1:0] pixel,
    output logic [8:0]              pixX,
    output logic [8:0]              pixY,
    output logic                    hs,
    output logic                    vs,
    output logic                    hb,
    output logic                    vb,
    output logic                    lineStart,
    output logic                    frameStart
);

    localparam vidPkg::vidTimingT timIdle = '{hb: 1'b1, vb: 1'b1, default: '0};

    vidPkg::priModeE   priMode;
    vidPkg::vidTimingT timD1;   // matches the layer pixels
    vidPkg::vidTimingT timD2;   // matches the mixed pixel

    vidPkg::layerPixT        frontPix;
    vidPkg::layerPixT        backPix;
    logic [3:0]              frontBank;
    logic [3:0]              backBank;
    logic [vidPkg::pixW-1:0] mixNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) priMode <= vidPkg::priObjFront;
        else if (cfgWe && cfgAddr == vidPkg::regPriority) priMode <= vidPkg::priModeE'(cfgData[0]);
    end

    always_comb begin
        if (priMode == vidPkg::priObjFront) begin
            frontPix  = objPix;
            frontBank = vidPkg::objBank;
            backPix   = bgPix;
            backBank  = vidPkg::bgBank;
        end else begin
            frontPix  = bgPix;
            frontBank = vidPkg::bgBank;
            backPix   = objPix;
            backBank  = vidPkg::objBank;
        end
        if (timD1.hb || timD1.vb) mixNext = vidPkg::backdrop;  // nothing drawn in blanking
        else if (frontPix.opaque) mixNext = {frontBank, frontPix.idx};
        else if (backPix.opaque) mixNext = {backBank, backPix.idx};
        else mixNext = vidPkg::backdrop;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timD1 <= timIdle;
            timD2 <= timIdle;
            pixel <= vidPkg::backdrop;
        end else if (cen8) begin
            timD1 <= tim;
            timD2 <= timD1;
            pixel <= mixNext;
        end
    end

    assign pixX       = timD2.hdump;
    assign pixY       = timD2.vdump;
    assign hs         = timD2.hs;
    assign vs         = timD2.vs;
    assign hb         = timD2.hb;
    assign vb         = timD2.vb;
    assign lineStart  = timD2.lineStart;
    assign frameStart = timD2.frameStart;

endmodule

// File: verilog/objLayer.sv
// object layer: position and colour registers, single square sprite hit test
`timescale 1ns/1ps

module objLayer #(
    parameter int objSize = 16  // sprite edge in pixels
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cen8,
    input  vidPkg::vidTimingT tim,
    input  logic              cfgWe,
    input  vidPkg::cfgRegE    cfgAddr,
    input  logic [8:0]        cfgData,
    output vidPkg::layerPixT  pix
);

    localparam logic [9:0] sizeW = 10'(objSize);

    logic [8:0] objX;
    logic [8:0] objY;
    logic [3:0] objColor;

    // bounds kept one bit wider so the sprite never wraps around
    logic [9:0] xEnd;
    logic [9:0] yEnd;
    logic       hitX;
    logic       hitY;
    logic       hit;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            objX     <= 9'd0;
            objY     <= 9'd0;
            objColor <= 4'd0;
        end else if (cfgWe) begin
            case (cfgAddr)
                vidPkg::regObjX:     objX     <= cfgData;
                vidPkg::regObjY:     objY     <= cfgData;
                vidPkg::regObjColor: objColor <= cfgData[3:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        xEnd = {1'b0, objX} + sizeW;
        yEnd = {1'b0, objY} + sizeW;
        hitX = tim.hdump >= objX && {1'b0, tim.hdump} < xEnd;
        hitY = tim.vdump >= objY && {1'b0, tim.vdump} < yEnd;
        hit  = hitX && hitY;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pix <= '0;
        end else if (cen8) begin
            if (hit) begin
                pix.idx    <= objColor;
                pix.opaque <= objColor != 4'd0;  // colour 0 is see-through
            end else begin
                pix <= '0;
            end
        end
    end

endmodule

// File: verilog/scrollLayer.sv
// background layer: scroll registers and procedural checkerboard tiles
`timescale 1ns/1ps

module scrollLayer (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cen8,
    input  vidPkg::vidTimingT tim,
    input  logic              cfgWe,
    input  vidPkg::cfgRegE    cfgAddr,
    input  logic [8:0]        cfgData,
    output vidPkg::layerPixT  pix
);

    logic [8:0] scrollX;
    logic [8:0] scrollY;

    logic [8:0] sx;      // scrolled column, wraps at 512
    logic [8:0] sy;      // scrolled row
    logic [8:0] tileMix;
    logic [3:0] tileIdx;

    // register writes ignore cen8
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scrollX <= 9'd0;
            scrollY <= 9'd0;
        end else if (cfgWe) begin
            case (cfgAddr)
                vidPkg::regScrollX: scrollX <= cfgData;
                vidPkg::regScrollY: scrollY <= cfgData;
                default: ;
            endcase
        end
    end

    always_comb begin
        sx      = tim.hdump + scrollX;   // 9-bit sum drops the carry
        sy      = tim.vdump + scrollY;
        tileMix = (sx ^ sy) >> 3;        // 8x8 pixel tiles
        tileIdx = tileMix[3:0];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pix <= '0;
        end else if (cen8) begin
            pix.idx    <= tileIdx;
            pix.opaque <= tileIdx != 4'd0;  // index 0 shows through
        end
    end

endmodule

// File: verilog/vidPkg.sv
// shared video types: timing bundle, layer pixel, register map
// plus palette and raster constants
package vidPkg;

    // raster geometry, counted in cen8 ticks and lines
    localparam int lineTicks  = 512;
    localparam int frameLines = 262;

    // visible window bounds
    localparam logic [8:0] hVisStart = 9'd64;
    localparam logic [8:0] hVisEnd   = 9'd448;   // 384 visible pixels
    localparam logic [8:0] vVisStart = 9'd14;
    localparam logic [8:0] vVisEnd   = 9'd238;   // 224 visible lines

    // palette index layout
    localparam int         pixW     = 8;
    localparam logic [3:0] bgBank   = 4'h1;
    localparam logic [3:0] objBank  = 4'h2;
    localparam logic [7:0] backdrop = 8'h00;

    // everything the layers and mixer need from the timing generator
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lineStart;
        logic       frameStart;
        logic       hs;
        logic       vs;
        logic       hb;
        logic       vb;
    } vidTimingT;

    // one layer's pixel before mixing
    typedef struct packed {
        logic       opaque;
        logic [3:0] idx;
    } layerPixT;

    // config write addresses, each block decodes its own
    typedef enum logic [2:0] {
        regScrollX  = 3'd0,
        regScrollY  = 3'd1,
        regObjX     = 3'd2,
        regObjY     = 3'd3,
        regObjColor = 3'd4,
        regPriority = 3'd5
    } cfgRegE;

    typedef enum logic {
        priObjFront = 1'b0,  // sprite over background
        priBgFront  = 1'b1
    } priModeE;

endpackage

// File: verilog/vidTiming.sv
// raster timing generator: h/v counters, blanking, sync, line and frame pulses
`timescale 1ns/1ps

module vidTiming #(
    parameter int hsStart = 487,  // larger values pull the picture left
    parameter int hsLen   = 38,
    parameter int vsStart = 251,  // larger values pull the picture up
    parameter int vsLen   = 4
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cen8,
    output vidPkg::vidTimingT tim
);

    // sync edges, hs end wraps past the line end
    localparam logic [8:0] hsOn  = 9'(hsStart);
    localparam logic [8:0] hsOff = 9'((hsStart + hsLen) % vidPkg::lineTicks);
    localparam logic [8:0] vsOn  = 9'(vsStart);
    localparam logic [8:0] vsOff = 9'(vsStart + vsLen);

    localparam logic [8:0] hLast = 9'(vidPkg::lineTicks - 1);
    localparam logic [8:0] vLast = 9'(vidPkg::frameLines - 1);

    // line pulse window on vdump, exclusive bounds
    localparam logic [8:0] lsLow  = 9'd12;
    localparam logic [8:0] lsHigh = 9'd240;

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic [8:0] vrender;   // one line ahead of vdump
    logic [8:0] vrender1;  // two lines ahead
    logic       hs;
    logic       vs;
    logic       hb;
    logic       vb;
    logic [1:0] vbPipe;    // vertical blank shifted along with the line pipeline
    logic       lineStart;
    logic       frameStart;

    logic       hWrap;
    logic       vBlankNow;

    assign hWrap     = hdump == hLast;
    assign vBlankNow = vdump < vidPkg::vVisStart || vdump >= vidPkg::vVisEnd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hdump      <= 9'd0;
            vdump      <= 9'd240;  // start inside vertical blank
            vrender    <= 9'd241;
            vrender1   <= 9'd242;
            hs         <= 1'b0;
            vs         <= 1'b0;
            hb         <= 1'b1;
            vb         <= 1'b1;
            vbPipe     <= 2'b11;
            lineStart  <= 1'b1;
            frameStart <= 1'b0;
        end else if (cen8) begin
            hdump     <= hdump + 9'd1;
            vbPipe[0] <= vBlankNow;
            hb        <= hdump >= vidPkg::hVisEnd || hdump < vidPkg::hVisStart;
            lineStart <= hWrap && vdump < lsHigh && vdump > lsLow;

            if (hdump == hsOn) begin
                hs <= 1'b1;
                // vs only moves together with the hs leading edge
                if (vdump == vsOn) vs <= 1'b1;
                if (vdump == vsOff) vs <= 1'b0;
            end
            if (hdump == hsOff) hs <= 1'b0;

            if (hWrap) begin
                hdump      <= 9'd0;
                vrender1   <= (vrender1 == vLast) ? 9'd0 : vrender1 + 9'd1;
                vrender    <= vrender1;
                vdump      <= vrender;
                vb         <= vbPipe[1];      // two line wraps behind the test
                vbPipe[1]  <= vbPipe[0];
                frameStart <= vrender1 == vLast;
            end else begin
                frameStart <= 1'b0;
            end
        end
    end

    assign tim = '{
        hdump:      hdump,
        vdump:      vdump,
        lineStart:  lineStart,
        frameStart: frameStart,
        hs:         hs,
        vs:         vs,
        hb:         hb,
        vb:         vb
    };

endmodule

// File: verilog/vidTop.sv
// video subsystem top: timing, background and object layers, mixer
`timescale 1ns/1ps

module vidTop #(
    parameter int hsStart = 487,
    parameter int hsLen   = 38,
    parameter int vsStart = 251,
    parameter int vsLen   = 4,
    parameter int objSize = 16
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    cen8,       // pixel clock enable
    input  logic                    cfgWe,
    input  vidPkg::cfgRegE          cfgAddr,
    input  logic [8:0]              cfgData,
    output logic [vidPkg::pixW-1:0] pixel,
    output logic [8:0]              pixX,
    output logic [8:0]              pixY,
    output logic                    hs,
    output logic                    vs,
    output logic                    hb,
    output logic                    vb,
    output logic                    lineStart,
    output logic                    frameStart
);

    vidPkg::vidTimingT tim;
    vidPkg::layerPixT  bgPix;
    vidPkg::layerPixT  objPix;

    vidTiming #(
        .hsStart (hsStart),
        .hsLen   (hsLen),
        .vsStart (vsStart),
        .vsLen   (vsLen)
    ) uTiming (
        .clk, .arstN, .cen8,
        .tim (tim)
    );

    scrollLayer uScroll (
        .clk, .arstN, .cen8, .tim,
        .cfgWe, .cfgAddr, .cfgData,
        .pix (bgPix)
    );

    objLayer #(.objSize(objSize)) uObj (
        .clk, .arstN, .cen8, .tim,
        .cfgWe, .cfgAddr, .cfgData,
        .pix (objPix)
    );

    layerMixer uMixer (
        .clk, .arstN, .cen8, .tim,
        .bgPix, .objPix,
        .cfgWe, .cfgAddr, .cfgData,
        .pixel, .pixX, .pixY,
        .hs, .vs, .hb, .vb,
        .lineStart, .frameStart
    );

endmodule
